// ==== Makefile ====
# Verilator build and run for the mini core testbench

BIN := obj_dir/Vmini_core_tb

.PHONY: all run clean

all: run

$(BIN): mini_core.f $(wildcard verilog/*.sv test/*.sv)
	verilator --binary -Wno-fatal -f mini_core.f --top-module mini_core_tb -o Vmini_core_tb

# Pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== mini_core.f ====
verilog/mini_isa_pkg.sv
verilog/mini_uarch_pkg.sv
verilog/mini_fetch.sv
verilog/mini_decode.sv
verilog/mini_execute.sv
verilog/mini_core.sv
test/mini_core_tb.sv

// ==== test/mini_core_input.txt ====
// Words at 0x00 are the program: op[15:12] rd[11:10] rs1[9:8] rs2[7:6] imm[7:0]
// Words at 0x40 are expected rd write data, words at 0x80 expected trap flags
@00
10FF  // LDI r0, 0xFF
1481  // LDI r1, 0x81
2840  // ADD r2, r0, r1
7E00  // SHL r3, r2
3D00  // SUB r3, r1, r0 wraps below zero
7F00  // SHL r3, r3 drops the top bit
4B00  // AND r2, r3, r0
56C0  // OR  r1, r2, r3
6100  // XOR r0, r1, r0
9B00  // illegal opcode 9 aimed at r2
0000  // NOP
2E80  // ADD r3, r2, r2 reads r2 left by the illegal word
2400  // ADD r0 + r0 into r1 wraps
8000  // HALT
@40
00FF
0081
0180
0300
FF82
FF04
0004
FF04
FFFB
0000
0000
0008
FFF6
0000
@80
0 0 0 0 0 0 0
0 0 1 0 0 0 0

// ==== test/mini_core_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mini core testbench
// Memory responder with random latency and retirement trace checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mini_core_tb;

  localparam int unsigned AddrWidth = 8;
  localparam int unsigned DataWidth = 16;
  localparam int unsigned BootAddr  = 0;
  localparam int unsigned MemWords  = 192;
  localparam int unsigned WdataBase = 64;
  localparam int unsigned TrapBase  = 128;

  logic                 clk = 1'b0;
  logic                 rst_i;
  logic                 fetch_enable_i;
  logic                 instr_rvalid_i = 1'b0;
  logic [15:0]          instr_rdata_i = '0;
  logic                 instr_req_o;
  logic [AddrWidth-1:0] instr_addr_o;
  logic                 retire_valid_o;
  logic [31:0]          retire_order_o;
  logic [AddrWidth-1:0] retire_pc_o;
  logic [15:0]          retire_insn_o;
  logic [1:0]           retire_rd_addr_o;
  logic [DataWidth-1:0] retire_rd_wdata_o;
  logic                 retire_trap_o;
  logic                 core_sleep_o;

  // Program at 0x00, expected write data at 0x40, trap flags at 0x80
  logic [15:0] input_mem [MemWords];

  int unsigned          prog_len = 0;
  int unsigned          cycle_limit = 60;
  int unsigned          cycle = 0;
  int unsigned          retired = 0;
  int unsigned          next_addr = BootAddr;
  int unsigned          delay_left = 0;
  logic                 pending = 1'b0;
  logic [AddrWidth-1:0] pending_addr = '0;
  int unsigned          rsp_cycles [$];
  int unsigned          lcg_state = 39401;
  int unsigned          mismatch_count = 0;
  int unsigned          fail_count = 0;

  mini_core #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .BootAddr  (BootAddr )
  ) dut (
    .clk_i             (clk              ),
    .rst_i             (rst_i            ),
    .fetch_enable_i    (fetch_enable_i   ),
    .instr_rvalid_i    (instr_rvalid_i   ),
    .instr_rdata_i     (instr_rdata_i    ),
    .instr_req_o       (instr_req_o      ),
    .instr_addr_o      (instr_addr_o     ),
    .retire_valid_o    (retire_valid_o   ),
    .retire_order_o    (retire_order_o   ),
    .retire_pc_o       (retire_pc_o      ),
    .retire_insn_o     (retire_insn_o    ),
    .retire_rd_addr_o  (retire_rd_addr_o ),
    .retire_rd_wdata_o (retire_rd_wdata_o),
    .retire_trap_o     (retire_trap_o    ),
    .core_sleep_o      (core_sleep_o     )
  );

  initial begin
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Only register-writing opcodes report a destination
  function automatic logic [1:0] expected_rd(input logic [15:0] insn);
    logic [3:0] op;
    op = insn[15:12];
    if (op >= mini_isa_pkg::LDI && op <= mini_isa_pkg::SHL) begin
      return insn[11:10];
    end
    return 2'd0;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    fail_count++;
  endtask

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  // Responder and trace checker, all on the falling edge
  always @(negedge clk) begin
    instr_rvalid_i = 1'b0;
    if (rst_i || !fetch_enable_i) begin
      if (instr_req_o) report_error("request while in reset or fetch disabled");
      if (retire_valid_o) report_error("retirement while in reset or fetch disabled");
    end
    compare_field("core_sleep_o", retired >= prog_len, core_sleep_o);
    if (pending) begin
      delay_left--;
      if (delay_left == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = input_mem[pending_addr];
        pending        = 1'b0;
        rsp_cycles.push_back(cycle);
      end
    end
    if (instr_req_o) begin
      if (pending) report_error("request while another one is outstanding");
      if (next_addr >= BootAddr + prog_len) report_error("request after HALT was fetched");
      compare_field("instr_addr_o", next_addr, instr_addr_o);
      next_addr++;
      pending      = 1'b1;
      pending_addr = instr_addr_o;
      delay_left   = 1 + (next_rand() >> 16) % 4;
    end
    if (retire_valid_o) begin
      if (retired >= prog_len) begin
        report_error("retirement after HALT");
      end else begin
        compare_field("retire_order_o", retired, retire_order_o);
        compare_field("retire_pc_o", BootAddr + retired, retire_pc_o);
        compare_field("retire_insn_o", input_mem[retired], retire_insn_o);
        compare_field("retire_rd_addr_o", expected_rd(input_mem[retired]), retire_rd_addr_o);
        compare_field("retire_rd_wdata_o", input_mem[WdataBase + retired], retire_rd_wdata_o);
        compare_field("retire_trap_o", input_mem[TrapBase + retired][0], retire_trap_o);
      end
      if (rsp_cycles.size() == 0) begin
        report_error("retirement without a preceding response");
      end else begin
        compare_field("retire_valid_o cycle", rsp_cycles.pop_front() + 2, cycle);
      end
      retired++;
    end
  end

  initial begin
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    $readmemh("test/mini_core_input.txt", input_mem);
    // Program runs up to the first HALT word
    for (int i = WdataBase - 1; i >= 0; i--) begin
      if (input_mem[i][15:12] == mini_isa_pkg::HALT) prog_len = i + 1;
    end
    cycle_limit = prog_len * 6 + 60;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    repeat (10) @(negedge clk);
    fetch_enable_i = 1'b1;
    wait (retired == prog_len);
    // Core stays asleep with no further fetches
    repeat (20) @(negedge clk);
    finish_run();
  end

  initial begin
    @(posedge clk);
    while (cycle < cycle_limit) @(posedge clk);
    report_error($sformatf("timeout after %0d cycles, %0d of %0d instructions retired",
                           cycle, retired, prog_len));
    finish_run();
  end

endmodule

// ==== verilog/mini_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mini core top level
// Fetch, decode and execute in a three stage pipe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mini_core #(
  parameter int unsigned AddrWidth = 8,
  parameter int unsigned DataWidth = 16,
  parameter int unsigned BootAddr  = 0
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  fetch_enable_i,
  input  logic                                  instr_rvalid_i,
  input  logic [mini_isa_pkg::InstrWidth-1:0]   instr_rdata_i,
  output logic                                  instr_req_o,
  output logic [AddrWidth-1:0]                  instr_addr_o,
  output logic                                  retire_valid_o,
  output logic [mini_uarch_pkg::OrderWidth-1:0] retire_order_o,
  output logic [AddrWidth-1:0]                  retire_pc_o,
  output logic [mini_isa_pkg::InstrWidth-1:0]   retire_insn_o,
  output logic [mini_isa_pkg::RegAddrWidth-1:0] retire_rd_addr_o,
  output logic [DataWidth-1:0]                  retire_rd_wdata_o,
  output logic                                  retire_trap_o,
  output logic                                  core_sleep_o
);

  // Fetch to decode
  logic                                  f_valid;
  logic [mini_isa_pkg::InstrWidth-1:0]   f_instr;
  logic [AddrWidth-1:0]                  f_pc;
  logic                                  f_halt;

  // Decode to execute
  logic                                  d_valid;
  mini_uarch_pkg::alu_op_e               d_op;
  logic [mini_isa_pkg::RegAddrWidth-1:0] d_rd;
  logic [mini_isa_pkg::RegAddrWidth-1:0] d_rs1;
  logic [mini_isa_pkg::RegAddrWidth-1:0] d_rs2;
  logic [DataWidth-1:0]                  d_imm;
  logic                                  d_write;
  logic                                  d_illegal;
  logic                                  d_halt;
  logic [AddrWidth-1:0]                  d_pc;
  logic [mini_isa_pkg::InstrWidth-1:0]   d_instr;

  mini_fetch #(
    .AddrWidth (AddrWidth),
    .BootAddr  (BootAddr )
  ) u_fetch (
    .clk_i          (clk_i         ),
    .rst_i          (rst_i         ),
    .fetch_enable_i (fetch_enable_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i ),
    .instr_req_o    (instr_req_o   ),
    .instr_addr_o   (instr_addr_o  ),
    .f_valid_o      (f_valid       ),
    .f_instr_o      (f_instr       ),
    .f_pc_o         (f_pc          ),
    .f_halt_o       (f_halt        )
  );

  mini_decode #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) u_decode (
    .clk_i       (clk_i    ),
    .rst_i       (rst_i    ),
    .f_valid_i   (f_valid  ),
    .f_instr_i   (f_instr  ),
    .f_pc_i      (f_pc     ),
    .f_halt_i    (f_halt   ),
    .d_valid_o   (d_valid  ),
    .d_op_o      (d_op     ),
    .d_rd_o      (d_rd     ),
    .d_rs1_o     (d_rs1    ),
    .d_rs2_o     (d_rs2    ),
    .d_imm_o     (d_imm    ),
    .d_write_o   (d_write  ),
    .d_illegal_o (d_illegal),
    .d_halt_o    (d_halt   ),
    .d_pc_o      (d_pc     ),
    .d_instr_o   (d_instr  )
  );

  mini_execute #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) u_execute (
    .clk_i             (clk_i            ),
    .rst_i             (rst_i            ),
    .d_valid_i         (d_valid          ),
    .d_op_i            (d_op             ),
    .d_rd_i            (d_rd             ),
    .d_rs1_i           (d_rs1            ),
    .d_rs2_i           (d_rs2            ),
    .d_imm_i           (d_imm            ),
    .d_write_i         (d_write          ),
    .d_illegal_i       (d_illegal        ),
    .d_halt_i          (d_halt           ),
    .d_pc_i            (d_pc             ),
    .d_instr_i         (d_instr          ),
    .retire_valid_o    (retire_valid_o   ),
    .retire_order_o    (retire_order_o   ),
    .retire_pc_o       (retire_pc_o      ),
    .retire_insn_o     (retire_insn_o    ),
    .retire_rd_addr_o  (retire_rd_addr_o ),
    .retire_rd_wdata_o (retire_rd_wdata_o),
    .retire_trap_o     (retire_trap_o    ),
    .core_sleep_o      (core_sleep_o     )
  );

endmodule

// ==== verilog/mini_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mini core decode stage
// Field split and opcode to ALU op mapping
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mini_decode #(
  parameter int unsigned AddrWidth = 8,
  parameter int unsigned DataWidth = 16
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  f_valid_i,
  input  logic [mini_isa_pkg::InstrWidth-1:0]   f_instr_i,
  input  logic [AddrWidth-1:0]                  f_pc_i,
  input  logic                                  f_halt_i,
  output logic                                  d_valid_o,
  output mini_uarch_pkg::alu_op_e               d_op_o,
  output logic [mini_isa_pkg::RegAddrWidth-1:0] d_rd_o,
  output logic [mini_isa_pkg::RegAddrWidth-1:0] d_rs1_o,
  output logic [mini_isa_pkg::RegAddrWidth-1:0] d_rs2_o,
  output logic [DataWidth-1:0]                  d_imm_o,
  output logic                                  d_write_o,
  output logic                                  d_illegal_o,
  output logic                                  d_halt_o,
  output logic [AddrWidth-1:0]                  d_pc_o,
  output logic [mini_isa_pkg::InstrWidth-1:0]   d_instr_o
);

  mini_isa_pkg::opcode_e   opcode;
  mini_uarch_pkg::alu_op_e alu_op;
  logic                    write_en;
  logic                    illegal;

  assign opcode = mini_isa_pkg::opcode_e'(
      f_instr_i[mini_isa_pkg::OpcodeMsb:mini_isa_pkg::OpcodeLsb]);

  always_comb begin
    alu_op   = mini_uarch_pkg::ALU_NONE;
    write_en = 1'b1;
    illegal  = 1'b0;
    case (opcode)
      mini_isa_pkg::LDI:  alu_op = mini_uarch_pkg::ALU_PASS_IMM;
      mini_isa_pkg::ADD:  alu_op = mini_uarch_pkg::ALU_ADD;
      mini_isa_pkg::SUB:  alu_op = mini_uarch_pkg::ALU_SUB;
      mini_isa_pkg::AND:  alu_op = mini_uarch_pkg::ALU_AND;
      mini_isa_pkg::OR:   alu_op = mini_uarch_pkg::ALU_OR;
      mini_isa_pkg::XOR:  alu_op = mini_uarch_pkg::ALU_XOR;
      mini_isa_pkg::SHL:  alu_op = mini_uarch_pkg::ALU_SHL;
      mini_isa_pkg::NOP,
      mini_isa_pkg::HALT: write_en = 1'b0;
      // Codes 9 to 15
      default: begin
        write_en = 1'b0;
        illegal  = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      d_valid_o <= 1'b0;
    end else begin
      d_valid_o <= f_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (f_valid_i) begin
      d_op_o      <= alu_op;
      d_rd_o      <= f_instr_i[mini_isa_pkg::RdMsb:mini_isa_pkg::RdLsb];
      d_rs1_o     <= f_instr_i[mini_isa_pkg::Rs1Msb:mini_isa_pkg::Rs1Lsb];
      d_rs2_o     <= f_instr_i[mini_isa_pkg::Rs2Msb:mini_isa_pkg::Rs2Lsb];
      // Zero-extended immediate
      d_imm_o     <= {{(DataWidth - mini_isa_pkg::ImmWidth){1'b0}},
                      f_instr_i[mini_isa_pkg::ImmMsb:mini_isa_pkg::ImmLsb]};
      d_write_o   <= write_en;
      d_illegal_o <= illegal;
      d_halt_o    <= f_halt_i;
      d_pc_o      <= f_pc_i;
      d_instr_o   <= f_instr_i;
    end
  end

endmodule

// ==== verilog/mini_execute.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mini core execute and retire stage
// Register file, ALU and retirement trace
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mini_execute #(
  parameter int unsigned AddrWidth = 8,
  parameter int unsigned DataWidth = 16
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  d_valid_i,
  input  mini_uarch_pkg::alu_op_e               d_op_i,
  input  logic [mini_isa_pkg::RegAddrWidth-1:0] d_rd_i,
  input  logic [mini_isa_pkg::RegAddrWidth-1:0] d_rs1_i,
  input  logic [mini_isa_pkg::RegAddrWidth-1:0] d_rs2_i,
  input  logic [DataWidth-1:0]                  d_imm_i,
  input  logic                                  d_write_i,
  input  logic                                  d_illegal_i,
  input  logic                                  d_halt_i,
  input  logic [AddrWidth-1:0]                  d_pc_i,
  input  logic [mini_isa_pkg::InstrWidth-1:0]   d_instr_i,
  output logic                                  retire_valid_o,
  output logic [mini_uarch_pkg::OrderWidth-1:0] retire_order_o,
  output logic [AddrWidth-1:0]                  retire_pc_o,
  output logic [mini_isa_pkg::InstrWidth-1:0]   retire_insn_o,
  output logic [mini_isa_pkg::RegAddrWidth-1:0] retire_rd_addr_o,
  output logic [DataWidth-1:0]                  retire_rd_wdata_o,
  output logic                                  retire_trap_o,
  output logic                                  core_sleep_o
);

  localparam int unsigned NumRegs = 2 ** mini_isa_pkg::RegAddrWidth;

  logic [DataWidth-1:0] rf_q [NumRegs];
  logic [DataWidth-1:0] rs1_val;
  logic [DataWidth-1:0] rs2_val;
  logic [DataWidth-1:0] result;
  logic                 rf_we;

  assign rs1_val = rf_q[d_rs1_i];
  assign rs2_val = rf_q[d_rs2_i];
  assign rf_we   = d_valid_i && d_write_i;

  // Results wrap at DataWidth
  always_comb begin
    case (d_op_i)
      mini_uarch_pkg::ALU_PASS_IMM: result = d_imm_i;
      mini_uarch_pkg::ALU_ADD:      result = rs1_val + rs2_val;
      mini_uarch_pkg::ALU_SUB:      result = rs1_val - rs2_val;
      mini_uarch_pkg::ALU_AND:      result = rs1_val & rs2_val;
      mini_uarch_pkg::ALU_OR:       result = rs1_val | rs2_val;
      mini_uarch_pkg::ALU_XOR:      result = rs1_val ^ rs2_val;
      mini_uarch_pkg::ALU_SHL:      result = rs1_val << 1;
      default:                      result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NumRegs; i++) begin
        rf_q[i] <= '0;
      end
    end else if (rf_we) begin
      rf_q[d_rd_i] <= result;
    end
  end

  // Order count advances once per retired instruction
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      retire_order_o <= '0;
      core_sleep_o   <= 1'b0;
    end else if (d_valid_i) begin
      retire_order_o <= retire_order_o + 1'b1;
      if (d_halt_i) begin
        core_sleep_o <= 1'b1;
      end
    end
  end

  // Trace is combinational from the decode registers
  assign retire_valid_o    = d_valid_i;
  assign retire_pc_o       = d_pc_i;
  assign retire_insn_o     = d_instr_i;
  assign retire_rd_addr_o  = d_write_i ? d_rd_i : '0;
  assign retire_rd_wdata_o = d_write_i ? result : '0;
  assign retire_trap_o     = d_illegal_i;

endmodule

// ==== verilog/mini_fetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mini core fetch stage
// One outstanding request, response registered to decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mini_fetch #(
  parameter int unsigned AddrWidth = 8,
  parameter int unsigned BootAddr  = 0
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                fetch_enable_i,
  input  logic                                instr_rvalid_i,
  input  logic [mini_isa_pkg::InstrWidth-1:0] instr_rdata_i,
  output logic                                instr_req_o,
  output logic [AddrWidth-1:0]                instr_addr_o,
  output logic                                f_valid_o,
  output logic [mini_isa_pkg::InstrWidth-1:0] f_instr_o,
  output logic [AddrWidth-1:0]                f_pc_o,
  output logic                                f_halt_o
);

  mini_uarch_pkg::fetch_state_e state_q;
  logic [AddrWidth-1:0]         pc_q;
  logic                         req_q;
  logic                         rsp_accept;
  logic                         rsp_is_halt;

  // Responses only count while a request is outstanding
  assign rsp_accept  = instr_rvalid_i && (state_q == mini_uarch_pkg::WAIT_RSP);
  assign rsp_is_halt = instr_rdata_i[mini_isa_pkg::OpcodeMsb:mini_isa_pkg::OpcodeLsb]
                       == mini_isa_pkg::HALT;

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= mini_uarch_pkg::IDLE;
      pc_q      <= AddrWidth'(BootAddr);
      req_q     <= 1'b0;
      f_valid_o <= 1'b0;
    end else begin
      req_q     <= 1'b0;
      f_valid_o <= rsp_accept;
      case (state_q)
        mini_uarch_pkg::IDLE: begin
          if (fetch_enable_i) begin
            req_q   <= 1'b1;
            state_q <= mini_uarch_pkg::WAIT_RSP;
          end
        end
        mini_uarch_pkg::WAIT_RSP: begin
          if (instr_rvalid_i) begin
            pc_q <= pc_q + 1'b1;
            if (rsp_is_halt) begin
              state_q <= mini_uarch_pkg::HALTED;
            end else if (fetch_enable_i) begin
              // Back-to-back: next request right after the response
              req_q <= 1'b1;
            end else begin
              state_q <= mini_uarch_pkg::IDLE;
            end
          end
        end
        // HALTED holds until reset
        default: state_q <= mini_uarch_pkg::HALTED;
      endcase
    end
  end

  // Word, its pc and the halt predecode
  always_ff @(posedge clk_i) begin
    if (rsp_accept) begin
      f_instr_o <= instr_rdata_i;
      f_pc_o    <= pc_q;
      f_halt_o  <= rsp_is_halt;
    end
  end

endmodule

// ==== verilog/mini_isa_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mini core ISA definitions
// Opcodes and instruction field layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mini_isa_pkg;

  // Instruction word and register file sizing
  parameter int unsigned InstrWidth   = 16;
  parameter int unsigned RegAddrWidth = 2;
  parameter int unsigned OpcodeWidth  = 4;

  // Opcode field
  parameter int unsigned OpcodeMsb = 15;
  parameter int unsigned OpcodeLsb = 12;

  // Register index fields
  parameter int unsigned RdMsb  = 11;
  parameter int unsigned RdLsb  = 10;
  parameter int unsigned Rs1Msb = 9;
  parameter int unsigned Rs1Lsb = 8;
  parameter int unsigned Rs2Msb = 7;
  parameter int unsigned Rs2Lsb = 6;

  // LDI immediate, overlaps rs2
  parameter int unsigned ImmMsb   = 7;
  parameter int unsigned ImmLsb   = 0;
  parameter int unsigned ImmWidth = ImmMsb - ImmLsb + 1;

  // Codes 9 to 15 are illegal
  typedef enum logic [OpcodeWidth-1:0] {
    NOP  = 4'd0,
    LDI  = 4'd1,
    ADD  = 4'd2,
    SUB  = 4'd3,
    AND  = 4'd4,
    OR   = 4'd5,
    XOR  = 4'd6,
    SHL  = 4'd7,   // rs1 shifted left by one
    HALT = 4'd8
  } opcode_e;

endpackage

// ==== verilog/mini_uarch_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mini core microarchitecture types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mini_uarch_pkg;

  // Width of the retirement order counter
  parameter int unsigned OrderWidth = 32;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_RSP,
    HALTED
  } fetch_state_e;

  typedef enum logic [2:0] {
    ALU_NONE,
    ALU_PASS_IMM,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHL
  } alu_op_e;

endpackage
